// File: dft_pkg.sv
`default_nettype none

package dft_pkg;

   // sample and word geometry
   localparam int SAMPLE_W = 16;
   localparam int CPLX_W = 2 * SAMPLE_W;
   localparam int WORD_W = 64;
   localparam int NUM_WORDS = 32;
   localparam int ADDR_W = 5;
   localparam int WORDS_PER_BLOCK = 4;
   localparam int BLOCK_W = WORDS_PER_BLOCK * WORD_W;

   // cos(pi/4) in Q15
   localparam int TWIDDLE_C = 23170;

   // bit positions in CTRL and STATUS
   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_IRQ_EN_BIT = 1;
   localparam int STATUS_DONE_BIT = 0;
   localparam int STATUS_BUSY_BIT = 1;

   // register offsets, word index taken from wb_adr_i[5:2]
   typedef enum logic [3:0] {
      REG_CTRL   = 4'd0,
      REG_WSTB   = 4'd1,
      REG_WADDR  = 4'd2,
      REG_WLO    = 4'd3,
      REG_WHI    = 4'd4,
      REG_RADDR  = 4'd5,
      REG_STATUS = 4'd6,
      REG_RLO    = 4'd7,
      REG_RHI    = 4'd8
   } reg_offset_e;

   typedef enum logic {
      SEQ_IDLE,
      SEQ_STREAM
   } seq_state_e;

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_FILL,
      CAP_DONE
   } cap_state_e;

endpackage

`default_nettype wire

// File: dft_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dft_regs (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire  [31:0] wb_adr_i,
   input  wire  [31:0] wb_dat_i,
   // byte selects are not supported, every access is a full word
   input  wire  [3:0]  wb_sel_i,
   input  wire         wb_we_i,
   input  wire         wb_stb_i,
   input  wire         wb_cyc_i,
   output logic [31:0] wb_dat_o,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic        int_o,
   input  wire         done_i,
   input  wire         busy_i,
   input  wire  [dft_pkg::WORD_W-1:0] rd_word_i,
   output logic        start_pulse_o,
   output logic        wr_pulse_o,
   output logic [dft_pkg::ADDR_W-1:0] wr_addr_o,
   output logic [dft_pkg::WORD_W-1:0] wr_word_o,
   output logic [dft_pkg::ADDR_W-1:0] rd_addr_o
);

   dft_pkg::reg_offset_e offset;
   logic                 access;
   logic                 mapped;

   logic [1:0]                  ctrl_q;
   logic                        wstb_q;
   logic [dft_pkg::ADDR_W-1:0]  waddr_q;
   logic [31:0]                 wlo_q;
   logic [31:0]                 whi_q;
   logic [dft_pkg::ADDR_W-1:0]  raddr_q;
   logic                        start_d;
   logic                        wstb_d;

   assign offset = dft_pkg::reg_offset_e'(wb_adr_i[5:2]);
   assign access = wb_cyc_i & wb_stb_i;
   assign mapped = wb_adr_i[5:2] <= dft_pkg::REG_RHI;

   // single cycle handshake, err takes the place of ack
   assign wb_ack_o = access & mapped;
   assign wb_err_o = access & ~mapped;

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         ctrl_q  <= '0;
         wstb_q  <= 1'b0;
         waddr_q <= '0;
         wlo_q   <= '0;
         whi_q   <= '0;
         raddr_q <= '0;
      end else if (wb_ack_o && wb_we_i) begin
         case (offset)
            dft_pkg::REG_CTRL:  ctrl_q  <= wb_dat_i[1:0];
            dft_pkg::REG_WSTB:  wstb_q  <= wb_dat_i[0];
            dft_pkg::REG_WADDR: waddr_q <= wb_dat_i[dft_pkg::ADDR_W-1:0];
            dft_pkg::REG_WLO:   wlo_q   <= wb_dat_i;
            dft_pkg::REG_WHI:   whi_q   <= wb_dat_i;
            dft_pkg::REG_RADDR: raddr_q <= wb_dat_i[dft_pkg::ADDR_W-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_d <= 1'b0;
         wstb_d  <= 1'b0;
      end else begin
         start_d <= ctrl_q[dft_pkg::CTRL_START_BIT];
         wstb_d  <= wstb_q;
      end
   end

   // rising edges; a start while busy is dropped
   assign start_pulse_o = ctrl_q[dft_pkg::CTRL_START_BIT] & ~start_d & ~busy_i;
   assign wr_pulse_o    = wstb_q & ~wstb_d;
   assign wr_addr_o     = waddr_q;
   assign wr_word_o     = {whi_q, wlo_q};
   assign rd_addr_o     = raddr_q;

   assign int_o = done_i & ctrl_q[dft_pkg::CTRL_IRQ_EN_BIT];

   always_comb begin
      wb_dat_o = '0;
      case (offset)
         dft_pkg::REG_CTRL:   wb_dat_o[1:0] = ctrl_q;
         dft_pkg::REG_WSTB:   wb_dat_o[0] = wstb_q;
         dft_pkg::REG_WADDR:  wb_dat_o[dft_pkg::ADDR_W-1:0] = waddr_q;
         dft_pkg::REG_WLO:    wb_dat_o = wlo_q;
         dft_pkg::REG_WHI:    wb_dat_o = whi_q;
         dft_pkg::REG_RADDR:  wb_dat_o[dft_pkg::ADDR_W-1:0] = raddr_q;
         dft_pkg::REG_STATUS: begin
            wb_dat_o[dft_pkg::STATUS_DONE_BIT] = done_i;
            wb_dat_o[dft_pkg::STATUS_BUSY_BIT] = busy_i;
         end
         dft_pkg::REG_RLO:    wb_dat_o = rd_word_i[31:0];
         dft_pkg::REG_RHI:    wb_dat_o = rd_word_i[63:32];
         default: ;
      endcase
   end

   a_ack_err_excl: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o));

   // result buffer must report busy right after an accepted start
   a_start_busy: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i) start_pulse_o |=> busy_i);

endmodule

`default_nettype wire

// File: dft_sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dft_sample_buffer (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         wr_pulse_i,
   input  wire  [dft_pkg::ADDR_W-1:0] wr_addr_i,
   input  wire  [dft_pkg::WORD_W-1:0] wr_word_i,
   input  wire         start_pulse_i,
   output logic        in_valid_o,
   output logic [dft_pkg::WORD_W-1:0] in_word_o
);

   logic [dft_pkg::WORD_W-1:0] mem [dft_pkg::NUM_WORDS];

   dft_pkg::seq_state_e        seq_state;
   logic [dft_pkg::ADDR_W-1:0] rd_addr;

   always_ff @(posedge wb_clk_i) begin
      if (wr_pulse_i) begin
         mem[wr_addr_i] <= wr_word_i;
      end
   end

   // walk addresses 0..31 once per start
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         seq_state <= dft_pkg::SEQ_IDLE;
         rd_addr   <= '0;
      end else begin
         case (seq_state)
            dft_pkg::SEQ_IDLE: begin
               if (start_pulse_i) begin
                  seq_state <= dft_pkg::SEQ_STREAM;
                  rd_addr   <= '0;
               end
            end
            dft_pkg::SEQ_STREAM: begin
               rd_addr <= rd_addr + 1'b1;
               if (int'(rd_addr) == dft_pkg::NUM_WORDS - 1) begin
                  seq_state <= dft_pkg::SEQ_IDLE;
               end
            end
            default: seq_state <= dft_pkg::SEQ_IDLE;
         endcase
      end
   end

   assign in_valid_o = (seq_state == dft_pkg::SEQ_STREAM);
   assign in_word_o  = mem[rd_addr];

   a_no_write_on_read: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wr_pulse_i && seq_state == dft_pkg::SEQ_STREAM && wr_addr_i == rd_addr));

endmodule

`default_nettype wire

// File: dft8_core.sv
`timescale 1ns/1ps
`default_nettype none

module dft8_core (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         in_valid_i,
   input  wire  [dft_pkg::WORD_W-1:0] in_word_i,
   output logic        out_valid_o,
   output logic [dft_pkg::WORD_W-1:0] out_word_o
);

   // a sample is {im, re}, sample n of a block sits at bits CPLX_W*n
   logic [dft_pkg::WORD_W-1:0]  g_word [dft_pkg::WORDS_PER_BLOCK-1];
   logic [1:0]                  g_cnt;
   logic                        blk_last;
   logic [dft_pkg::BLOCK_W-1:0] nat;
   logic [dft_pkg::BLOCK_W-1:0] brev;

   logic [dft_pkg::BLOCK_W-1:0] s1;
   logic [dft_pkg::BLOCK_W-1:0] s2;
   logic [dft_pkg::BLOCK_W-1:0] s3;
   logic                        s1_v;
   logic                        s2_v;
   logic                        s3_v;

   logic [dft_pkg::BLOCK_W-dft_pkg::WORD_W-1:0] ser_buf;
   logic [1:0]                                  ser_left;

   function automatic int rev3(input int n);
      return (n % 2) * 4 + ((n / 2) % 2) * 2 + (n / 4) % 2;
   endfunction

   // radix-2 butterfly, k selects W8^k; returns {a', b'}
   function automatic logic [2*dft_pkg::CPLX_W-1:0] bfly(
      input logic [dft_pkg::CPLX_W-1:0] a,
      input logic [dft_pkg::CPLX_W-1:0] b,
      input logic [1:0] k
   );
      logic signed [dft_pkg::SAMPLE_W-1:0]   ar;
      logic signed [dft_pkg::SAMPLE_W-1:0]   ai;
      logic signed [dft_pkg::SAMPLE_W-1:0]   br;
      logic signed [dft_pkg::SAMPLE_W-1:0]   bi;
      logic signed [2*dft_pkg::SAMPLE_W:0]   c_s;
      logic signed [2*dft_pkg::SAMPLE_W:0]   pr;
      logic signed [2*dft_pkg::SAMPLE_W:0]   pi;
      logic signed [dft_pkg::SAMPLE_W+1:0]   tr;
      logic signed [dft_pkg::SAMPLE_W+1:0]   ti;
      logic signed [dft_pkg::SAMPLE_W+2:0]   sr;
      logic signed [dft_pkg::SAMPLE_W+2:0]   si;
      logic signed [dft_pkg::SAMPLE_W+2:0]   dr;
      logic signed [dft_pkg::SAMPLE_W+2:0]   di;
      ar  = a[dft_pkg::SAMPLE_W-1:0];
      ai  = a[dft_pkg::CPLX_W-1:dft_pkg::SAMPLE_W];
      br  = b[dft_pkg::SAMPLE_W-1:0];
      bi  = b[dft_pkg::CPLX_W-1:dft_pkg::SAMPLE_W];
      c_s = dft_pkg::TWIDDLE_C;
      pr  = '0;
      pi  = '0;
      case (k)
         2'd0: begin
            tr = br;
            ti = bi;
         end
         2'd1: begin
            // (C, -C)
            pr = c_s * br + c_s * bi;
            pi = c_s * bi - c_s * br;
            tr = pr[2*dft_pkg::SAMPLE_W:dft_pkg::SAMPLE_W-1];
            ti = pi[2*dft_pkg::SAMPLE_W:dft_pkg::SAMPLE_W-1];
         end
         2'd2: begin
            // -j
            tr = bi;
            ti = -br;
         end
         default: begin
            // (-C, -C)
            pr = c_s * bi - c_s * br;
            pi = -(c_s * br + c_s * bi);
            tr = pr[2*dft_pkg::SAMPLE_W:dft_pkg::SAMPLE_W-1];
            ti = pi[2*dft_pkg::SAMPLE_W:dft_pkg::SAMPLE_W-1];
         end
      endcase
      sr = ar + tr;
      si = ai + ti;
      dr = ar - tr;
      di = ai - ti;
      // scale by 1/2 per stage
      return {si[dft_pkg::SAMPLE_W:1], sr[dft_pkg::SAMPLE_W:1],
              di[dft_pkg::SAMPLE_W:1], dr[dft_pkg::SAMPLE_W:1]};
   endfunction

   // one DIT stage with butterfly span half
   function automatic logic [dft_pkg::BLOCK_W-1:0] dit_stage(
      input logic [dft_pkg::BLOCK_W-1:0] v,
      input int half
   );
      logic [dft_pkg::BLOCK_W-1:0]    r;
      logic [2*dft_pkg::CPLX_W-1:0]   bf;
      int                             top;
      int                             bot;
      r = v;
      for (int g = 0; g < 2 * dft_pkg::WORDS_PER_BLOCK; g += 2 * half) begin
         for (int i = 0; i < half; i++) begin
            top = g + i;
            bot = top + half;
            bf  = bfly(v[dft_pkg::CPLX_W*top +: dft_pkg::CPLX_W],
                       v[dft_pkg::CPLX_W*bot +: dft_pkg::CPLX_W],
                       2'(i * (4 / half)));
            r[dft_pkg::CPLX_W*top +: dft_pkg::CPLX_W] = bf[2*dft_pkg::CPLX_W-1:dft_pkg::CPLX_W];
            r[dft_pkg::CPLX_W*bot +: dft_pkg::CPLX_W] = bf[dft_pkg::CPLX_W-1:0];
         end
      end
      return r;
   endfunction

   // gather the first three words, the fourth is used live
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         g_cnt <= '0;
      end else if (in_valid_i) begin
         g_cnt <= g_cnt + 1'b1;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (in_valid_i && !blk_last) begin
         g_word[g_cnt] <= in_word_i;
      end
   end

   assign blk_last = in_valid_i && (int'(g_cnt) == dft_pkg::WORDS_PER_BLOCK - 1);
   assign nat      = {in_word_i, g_word[2], g_word[1], g_word[0]};

   always_comb begin
      for (int n = 0; n < 2 * dft_pkg::WORDS_PER_BLOCK; n++) begin
         brev[dft_pkg::CPLX_W*n +: dft_pkg::CPLX_W] = nat[dft_pkg::CPLX_W*rev3(n) +: dft_pkg::CPLX_W];
      end
   end

   always_ff @(posedge wb_clk_i) begin
      s1 <= dit_stage(brev, 1);
      s2 <= dit_stage(s1, 2);
      s3 <= dit_stage(s2, 4);
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         s1_v <= 1'b0;
         s2_v <= 1'b0;
         s3_v <= 1'b0;
      end else begin
         s1_v <= blk_last;
         s2_v <= s1_v;
         s3_v <= s2_v;
      end
   end

   // output serializer, X0/X1 first
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         out_valid_o <= 1'b0;
         ser_left    <= '0;
      end else if (s3_v) begin
         out_valid_o <= 1'b1;
         ser_left    <= 2'd3;
      end else if (ser_left != 2'd0) begin
         ser_left <= ser_left - 1'b1;
      end else begin
         out_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (s3_v) begin
         out_word_o <= s3[dft_pkg::WORD_W-1:0];
         ser_buf    <= s3[dft_pkg::BLOCK_W-1:dft_pkg::WORD_W];
      end else begin
         out_word_o <= ser_buf[dft_pkg::WORD_W-1:0];
         ser_buf    <= ser_buf >> dft_pkg::WORD_W;
      end
   end

   a_ser_free: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i) s3_v |-> ser_left == 2'd0);

endmodule

`default_nettype wire

// File: dft_result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dft_result_buffer (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         start_pulse_i,
   input  wire         out_valid_i,
   input  wire  [dft_pkg::WORD_W-1:0] out_word_i,
   input  wire  [dft_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [dft_pkg::WORD_W-1:0] rd_word_o,
   output logic        done_o,
   output logic        busy_o
);

   logic [dft_pkg::WORD_W-1:0] mem [dft_pkg::NUM_WORDS];

   dft_pkg::cap_state_e        cap_state;
   logic [dft_pkg::ADDR_W-1:0] cap_cnt;
   logic                       cap_we;

   assign cap_we = out_valid_i && (cap_state == dft_pkg::CAP_FILL);

   always_ff @(posedge wb_clk_i) begin
      if (cap_we) begin
         mem[cap_cnt] <= out_word_i;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         cap_state <= dft_pkg::CAP_IDLE;
         cap_cnt   <= '0;
      end else if (start_pulse_i && cap_state != dft_pkg::CAP_FILL) begin
         // new run drops the old done
         cap_state <= dft_pkg::CAP_FILL;
         cap_cnt   <= '0;
      end else if (cap_we) begin
         cap_cnt <= cap_cnt + 1'b1;
         if (int'(cap_cnt) == dft_pkg::NUM_WORDS - 1) begin
            cap_state <= dft_pkg::CAP_DONE;
         end
      end
   end

   assign done_o    = (cap_state == dft_pkg::CAP_DONE);
   assign busy_o    = (cap_state == dft_pkg::CAP_FILL);
   assign rd_word_o = mem[rd_addr_i];

   a_no_late_words: assert property (
      @(posedge wb_clk_i) disable iff (wb_rst_i)
      !(out_valid_i && cap_state == dft_pkg::CAP_DONE));

endmodule

`default_nettype wire

// File: dft_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module dft_wb_top (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire  [31:0] wb_adr_i,
   input  wire  [31:0] wb_dat_i,
   input  wire  [3:0]  wb_sel_i,
   input  wire         wb_we_i,
   input  wire         wb_stb_i,
   input  wire         wb_cyc_i,
   output wire  [31:0] wb_dat_o,
   output wire         wb_ack_o,
   output wire         wb_err_o,
   output wire         int_o
);

   wire                        start_pulse;
   wire                        wr_pulse;
   wire [dft_pkg::ADDR_W-1:0]  wr_addr;
   wire [dft_pkg::WORD_W-1:0]  wr_word;
   wire [dft_pkg::ADDR_W-1:0]  rd_addr;
   wire [dft_pkg::WORD_W-1:0]  rd_word;
   wire                        done;
   wire                        busy;
   wire                        in_valid;
   wire [dft_pkg::WORD_W-1:0]  in_word;
   wire                        out_valid;
   wire [dft_pkg::WORD_W-1:0]  out_word;

   dft_regs u_regs (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_sel_i      (wb_sel_i),
      .wb_we_i       (wb_we_i),
      .wb_stb_i      (wb_stb_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .wb_err_o      (wb_err_o),
      .int_o         (int_o),
      .done_i        (done),
      .busy_i        (busy),
      .rd_word_i     (rd_word),
      .start_pulse_o (start_pulse),
      .wr_pulse_o    (wr_pulse),
      .wr_addr_o     (wr_addr),
      .wr_word_o     (wr_word),
      .rd_addr_o     (rd_addr)
   );

   dft_sample_buffer u_samples (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .wr_pulse_i    (wr_pulse),
      .wr_addr_i     (wr_addr),
      .wr_word_i     (wr_word),
      .start_pulse_i (start_pulse),
      .in_valid_o    (in_valid),
      .in_word_o     (in_word)
   );

   dft8_core u_core (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .in_valid_i  (in_valid),
      .in_word_i   (in_word),
      .out_valid_o (out_valid),
      .out_word_o  (out_word)
   );

   dft_result_buffer u_results (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .start_pulse_i (start_pulse),
      .out_valid_i   (out_valid),
      .out_word_i    (out_word),
      .rd_addr_i     (rd_addr),
      .rd_word_o     (rd_word),
      .done_o        (done),
      .busy_o        (busy)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o
);

   // 8 ns period
   localparam real HALF_PERIOD_NS = 4.0;

   initial begin
      clk_o = 1'b0;
      forever begin
         #(HALF_PERIOD_NS) clk_o = ~clk_o;
      end
   end

endmodule

`default_nettype wire

// File: tb_dft.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dft;

   localparam int NUM_TESTS = 6;
   localparam int CYCLES_PER_TEST = 400;
   localparam int CLK_NS = 8;
   localparam int POLL_LIMIT = 100;
   localparam int NUM_BLOCKS = dft_pkg::NUM_WORDS / dft_pkg::WORDS_PER_BLOCK;

   wire         wb_clk;
   logic        wb_rst;
   logic [31:0] wb_adr;
   logic [31:0] wb_wdat;
   logic [3:0]  wb_sel;
   logic        wb_we;
   logic        wb_stb;
   logic        wb_cyc;
   wire  [31:0] wb_rdat;
   wire         wb_ack;
   wire         wb_err;
   wire         irq;

   logic [dft_pkg::WORD_W-1:0] samples_q [dft_pkg::NUM_WORDS];
   logic [dft_pkg::WORD_W-1:0] expect_q [dft_pkg::NUM_WORDS];
   logic [15:0]                lfsr_q;
   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int test_err_base;

   tb_clock_gen u_clk (.clk_o(wb_clk));

   dft_wb_top uut (
      .wb_clk_i (wb_clk),
      .wb_rst_i (wb_rst),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_wdat),
      .wb_sel_i (wb_sel),
      .wb_we_i  (wb_we),
      .wb_stb_i (wb_stb),
      .wb_cyc_i (wb_cyc),
      .wb_dat_o (wb_rdat),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err),
      .int_o    (irq)
   );

   // galois form, taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic int rand_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         r = (r << 1) | int'(lfsr_q[0]);
         lfsr_q = lfsr_step(lfsr_q);
      end
      return r;
   endfunction

   // sign bit plus 13 bit magnitude, so within +-8191
   function automatic int rand_sample();
      int sign;
      int mag;
      sign = rand_bits(1);
      mag = rand_bits(13);
      return (sign != 0) ? -mag : mag;
   endfunction

   function automatic logic [dft_pkg::WORD_W-1:0] pack_word(input int re0, input int im0,
                                                            input int re1, input int im1);
      return {16'(im1), 16'(re1), 16'(im0), 16'(re0)};
   endfunction

   // signed 16 bit slot of a word
   function automatic int field(input logic [dft_pkg::WORD_W-1:0] w, input int slot);
      logic signed [dft_pkg::SAMPLE_W-1:0] v;
      v = w[dft_pkg::SAMPLE_W*slot +: dft_pkg::SAMPLE_W];
      return v;
   endfunction

   function automatic int bitrev3(input int n);
      logic [2:0] v;
      v = 3'(n);
      return int'({v[0], v[1], v[2]});
   endfunction

   // reference model, 3 DIT stages, each output halved
   task automatic ref_dft();
      int xr [8];
      int xi [8];
      int ar, ai, br, bi, tr, ti, p1, p2, top, bot, k, s;
      for (int b = 0; b < NUM_BLOCKS; b++) begin
         for (int n = 0; n < 8; n++) begin
            s = bitrev3(n);
            xr[n] = field(samples_q[4*b + s/2], 2*(s%2));
            xi[n] = field(samples_q[4*b + s/2], 2*(s%2) + 1);
         end
         for (int span = 1; span < 8; span *= 2) begin
            for (int g = 0; g < 8; g += 2*span) begin
               for (int i = 0; i < span; i++) begin
                  top = g + i;
                  bot = top + span;
                  k = i * (4 / span);
                  ar = xr[top];
                  ai = xi[top];
                  br = xr[bot];
                  bi = xi[bot];
                  p1 = dft_pkg::TWIDDLE_C * br;
                  p2 = dft_pkg::TWIDDLE_C * bi;
                  case (k)
                     0: begin
                        tr = br;
                        ti = bi;
                     end
                     1: begin
                        tr = (p1 + p2) >>> 15;
                        ti = (p2 - p1) >>> 15;
                     end
                     2: begin
                        tr = bi;
                        ti = -br;
                     end
                     default: begin
                        tr = (p2 - p1) >>> 15;
                        ti = (-p1 - p2) >>> 15;
                     end
                  endcase
                  xr[top] = (ar + tr) >>> 1;
                  xi[top] = (ai + ti) >>> 1;
                  xr[bot] = (ar - tr) >>> 1;
                  xi[bot] = (ai - ti) >>> 1;
               end
            end
         end
         for (int m = 0; m < 4; m++) begin
            expect_q[4*b + m] = pack_word(xr[2*m], xi[2*m], xr[2*m+1], xi[2*m+1]);
         end
      end
   endtask

   task automatic check_word(input string name, input logic [dft_pkg::WORD_W-1:0] got,
                             input logic [dft_pkg::WORD_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // one access per clock, entered and left 1 ns after a rising edge
   task automatic bus_cycle(input logic [3:0] off, input logic we, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic ack, output logic err);
      wb_adr = {26'd0, off, 2'b00};
      wb_wdat = wdata;
      wb_we = we;
      wb_stb = 1'b1;
      wb_cyc = 1'b1;
      #2;
      rdata = wb_rdat;
      ack = wb_ack;
      err = wb_err;
      @(posedge wb_clk);
      #1;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic wb_write(input logic [3:0] off, input logic [31:0] data);
      logic [31:0] unused;
      logic        ack;
      logic        err;
      bus_cycle(off, 1'b1, data, unused, ack, err);
      if (!ack || err) begin
         $display("write to offset %0d at %0t was not acknowledged", off, $time);
         errors++;
      end
   endtask

   task automatic wb_read(input logic [3:0] off, output logic [31:0] data);
      logic ack;
      logic err;
      bus_cycle(off, 1'b0, 32'd0, data, ack, err);
      if (!ack || err) begin
         $display("read of offset %0d at %0t was not acknowledged", off, $time);
         errors++;
      end
   endtask

   // WLO and WHI are only rewritten when they change
   task automatic load_words();
      logic [31:0] lo_w;
      logic [31:0] hi_w;
      bit          first;
      first = 1'b1;
      for (int a = 0; a < dft_pkg::NUM_WORDS; a++) begin
         wb_write(dft_pkg::REG_WADDR, a);
         if (first || samples_q[a][31:0] != lo_w) begin
            lo_w = samples_q[a][31:0];
            wb_write(dft_pkg::REG_WLO, lo_w);
         end
         if (first || samples_q[a][63:32] != hi_w) begin
            hi_w = samples_q[a][63:32];
            wb_write(dft_pkg::REG_WHI, hi_w);
         end
         wb_write(dft_pkg::REG_WSTB, 32'd1);
         wb_write(dft_pkg::REG_WSTB, 32'd0);
         first = 1'b0;
      end
   endtask

   task automatic wait_done();
      logic [31:0] st;
      int          polls;
      st = '0;
      polls = 0;
      while (!st[dft_pkg::STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
         wb_read(dft_pkg::REG_STATUS, st);
         polls++;
      end
      if (!st[dft_pkg::STATUS_DONE_BIT]) begin
         $display("done did not rise within %0d status polls at %0t", POLL_LIMIT, $time);
         errors++;
      end
   endtask

   task automatic run_dft(input logic irq_en);
      wb_write(dft_pkg::REG_CTRL, {30'd0, irq_en, 1'b1});
      wb_write(dft_pkg::REG_CTRL, {30'd0, irq_en, 1'b0});
      wait_done();
   endtask

   task automatic read_results();
      logic [31:0] lo_w;
      logic [31:0] hi_w;
      for (int a = 0; a < dft_pkg::NUM_WORDS; a++) begin
         wb_write(dft_pkg::REG_RADDR, a);
         wb_read(dft_pkg::REG_RLO, lo_w);
         wb_read(dft_pkg::REG_RHI, hi_w);
         check_word($sformatf("result word %0d", a), {hi_w, lo_w}, expect_q[a]);
      end
   endtask

   task automatic finish_test(input int num, input string name);
      tests_run++;
      if (errors == test_err_base) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED, %0d errors", num, name, errors - test_err_base);
      end
      test_err_base = errors;
   endtask

   task automatic test_regs();
      logic [31:0] d;
      logic        ack;
      logic        err;
      wb_write(dft_pkg::REG_WADDR, 32'h15);
      wb_write(dft_pkg::REG_WLO, 32'hA5A5_1234);
      wb_write(dft_pkg::REG_WHI, 32'h0F0F_BEEF);
      wb_write(dft_pkg::REG_RADDR, 32'h0A);
      wb_read(dft_pkg::REG_WADDR, d);
      check_word("wb_dat_o WADDR", {32'd0, d}, 64'h15);
      wb_read(dft_pkg::REG_WLO, d);
      check_word("wb_dat_o WLO", {32'd0, d}, 64'hA5A5_1234);
      wb_read(dft_pkg::REG_WHI, d);
      check_word("wb_dat_o WHI", {32'd0, d}, 64'h0F0F_BEEF);
      wb_read(dft_pkg::REG_RADDR, d);
      check_word("wb_dat_o RADDR", {32'd0, d}, 64'h0A);
      // offsets past RHI are unmapped
      bus_cycle(4'd9, 1'b0, 32'd0, d, ack, err);
      check_bit("wb_ack_o", ack, 1'b0);
      check_bit("wb_err_o", err, 1'b1);
      bus_cycle(4'd15, 1'b1, 32'hFFFF_FFFF, d, ack, err);
      check_bit("wb_ack_o", ack, 1'b0);
      check_bit("wb_err_o", err, 1'b1);
      finish_test(1, "register readback");
   endtask

   task automatic test_impulse();
      for (int a = 0; a < dft_pkg::NUM_WORDS; a++) begin
         samples_q[a] = (a % 4 == 0) ? pack_word(8192, 0, 0, 0) : '0;
         expect_q[a] = pack_word(1024, 0, 1024, 0);
      end
      load_words();
      run_dft(1'b0);
      read_results();
      finish_test(2, "impulse");
   endtask

   task automatic test_dc();
      for (int a = 0; a < dft_pkg::NUM_WORDS; a++) begin
         samples_q[a] = pack_word(800, -400, 800, -400);
         expect_q[a] = (a % 4 == 0) ? pack_word(800, -400, 0, 0) : '0;
      end
      load_words();
      run_dft(1'b0);
      read_results();
      finish_test(3, "dc");
   endtask

   task automatic load_random();
      for (int a = 0; a < dft_pkg::NUM_WORDS; a++) begin
         samples_q[a][15:0] = 16'(rand_sample());
         samples_q[a][31:16] = 16'(rand_sample());
         samples_q[a][47:32] = 16'(rand_sample());
         samples_q[a][63:48] = 16'(rand_sample());
      end
      ref_dft();
      load_words();
   endtask

   task automatic test_random();
      load_random();
      run_dft(1'b0);
      read_results();
      finish_test(4, "random blocks");
   endtask

   task automatic test_status_irq();
      logic [31:0] st;
      wb_write(dft_pkg::REG_CTRL, 32'h3);
      wb_write(dft_pkg::REG_CTRL, 32'h2);
      wb_read(dft_pkg::REG_STATUS, st);
      check_bit("status done", st[dft_pkg::STATUS_DONE_BIT], 1'b0);
      check_bit("status busy", st[dft_pkg::STATUS_BUSY_BIT], 1'b1);
      check_bit("int_o", irq, 1'b0);
      wait_done();
      check_bit("int_o", irq, 1'b1);
      wb_write(dft_pkg::REG_CTRL, 32'h0);
      check_bit("int_o", irq, 1'b0);
      // second start without irq enable
      wb_write(dft_pkg::REG_CTRL, 32'h1);
      wb_write(dft_pkg::REG_CTRL, 32'h0);
      wb_read(dft_pkg::REG_STATUS, st);
      check_bit("status done", st[dft_pkg::STATUS_DONE_BIT], 1'b0);
      wait_done();
      check_bit("int_o", irq, 1'b0);
      finish_test(5, "status and interrupt");
   endtask

   task automatic test_back_to_back();
      load_random();
      run_dft(1'b0);
      read_results();
      finish_test(6, "back-to-back runs");
   endtask

   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_NS);
      $display("watchdog expired, the run did not finish in time");
      $display("Some tests failed");
      $finish;
   end

   initial begin
      wb_rst = 1'b1;
      wb_adr = '0;
      wb_wdat = '0;
      wb_sel = 4'hF;
      wb_we = 1'b0;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      lfsr_q = 16'd65;
      errors = 0;
      checks = 0;
      tests_run = 0;
      tests_failed = 0;
      test_err_base = 0;
      repeat (16) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      test_regs();
      test_impulse();
      test_dc();
      test_random();
      test_status_irq();
      test_back_to_back();
      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
dft_pkg.sv
dft_regs.sv
dft_sample_buffer.sv
dft8_core.sv
dft_result_buffer.sv
dft_wb_top.sv
tb_clock_gen.sv
tb_dft.sv

// File: run.sh
#!/bin/sh
# compile and run the DFT testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dft -f project.f \
   && ./obj_dir/Vtb_dft > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All tests passed$" sim.log 2>/dev/null \
   && echo "simulation passed" \
   && exit 0
echo "simulation failed" || true
exit 1
